/* src.f */
source/pic_pkg.sv
source/pic_reg_file.sv
source/pic_gateway_array.sv
source/pic_priority_tree.sv
source/pic_claim_stage.sv
source/pic_ctrl.sv
sim/pic_ctrl_assert.sv
sim/pic_ctrl_tb.sv

/* Bender.yml */
package:
  name: pic_ctrl

sources:
  - source/pic_pkg.sv
  - source/pic_reg_file.sv
  - source/pic_gateway_array.sv
  - source/pic_priority_tree.sv
  - source/pic_claim_stage.sv
  - source/pic_ctrl.sv
  - target: simulation
    files:
      - sim/pic_ctrl_assert.sv
      - sim/pic_ctrl_tb.sv

/* sim/pic_ctrl_tb.sv */
// PIC controller testbench
// Drives the register port, the sources and the threshold levels of
// pic_ctrl and checks read data and core outputs against a model

module pic_ctrl_tb;

   localparam int          NUM_SRC    = 32;
   localparam logic [31:0] BASE       = 32'hF00C_0000;
   localparam int          CLK_PERIOD = 20;
   localparam int          SEED       = 32'h61a3_2c2c;
   localparam int          N_REG      = 40;
   localparam int          N_BYP      = 10;
   localparam int          N_ARB      = 60;
   localparam int          N_THR      = 64;   // 2 modes, 2 levels, 16 thresholds
   localparam int          N_GW       = 6;
   localparam int          NUM_TESTS  = N_REG + N_BYP + N_ARB + N_THR + N_GW;
   localparam longint      WATCHDOG   = (NUM_TESTS * 40 + 1000) * CLK_PERIOD;

   typedef struct packed {
      pic_pkg::id_t   id;
      pic_pkg::prio_t pl;
      logic           ext_pend;
      logic           wake;
   } claim_exp_t;

   logic                 clk;
   logic                 reset;
   logic                 picm_rden;
   logic [31:0]          picm_rdaddr;
   logic                 picm_wren;
   logic [31:0]          picm_wraddr;
   logic [31:0]          picm_wr_data;
   logic [NUM_SRC-1:0]   extintsrc_req;
   pic_pkg::prio_t       meipt;
   pic_pkg::prio_t       meicurpl;
   logic [31:0]          picm_rd_data;
   pic_pkg::id_t         claimid;
   pic_pkg::prio_t       pl;
   logic                 mexintpend;
   logic                 mhwakeup;

   // Model copies of the registers and source levels
   pic_pkg::prio_t       m_prio   [NUM_SRC];
   logic                 m_enable [NUM_SRC];
   pic_pkg::gw_cfg_t     m_gw_cfg [NUM_SRC];
   logic                 m_reverse;
   logic [NUM_SRC-1:0]   m_src;
   logic [NUM_SRC-1:0]   m_sticky;     // Edge gateway pending flops
   pic_pkg::prio_t       m_thr;
   pic_pkg::prio_t       m_cur;
   string                cur_test;
   event                 check_req;
   logic                 check_busy;   // High while the compare process works

   pic_ctrl #(.NUM_SOURCES(NUM_SRC), .BASE_ADDR(BASE), .TWO_CYCLE(0)) pic_ctrl_inst (
      .clk, .reset, .picm_rden, .picm_rdaddr, .picm_wren, .picm_wraddr, .picm_wr_data,
      .extintsrc_req, .meipt, .meicurpl,
      .picm_rd_data, .claimid, .pl, .mexintpend, .mhwakeup
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin : watchdog
      #(WATCHDOG);
      $display("Timeout: run still busy after %0d time units", WATCHDOG);
      $display("Test failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin : assertion_watch
      wait (pic_ctrl_inst.assert_inst.failures != 0);
      $display("A concurrent assertion on pic_ctrl failed");
      $display("Test failed");
      $fatal(1, "Run stopped at the first assertion failure");
   end

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] reg_addr(input int kind, input int idx);
      logic [31:0] offset;
      case (kind)
         0:       offset = pic_pkg::PRIO_OFFSET;
         1:       offset = pic_pkg::ENABLE_OFFSET;
         2:       offset = pic_pkg::GW_CONFIG_OFFSET;
         default: return BASE + pic_pkg::CONFIG_OFFSET;   // Single register
      endcase
      return BASE + offset + 32'(4 * idx);
   endfunction

   function automatic logic [31:0] exp_read(input int kind, input int idx);
      if (kind == 3) begin
         return {31'b0, m_reverse};
      end
      if (idx == 0) begin
         return '0;   // Reserved source
      end
      case (kind)
         0:       return {28'b0, m_prio[idx]};
         1:       return {31'b0, m_enable[idx]};
         default: return {30'b0, m_gw_cfg[idx]};
      endcase
   endfunction

   function automatic logic [NUM_SRC-1:0] pend_model();
      logic [NUM_SRC-1:0] pend;
      logic               lvl;
      pend = '0;
      for (int i = 1; i < NUM_SRC; i++) begin
         lvl     = m_src[i] ^ m_gw_cfg[i].polarity;
         pend[i] = lvl | (m_gw_cfg[i].edge_mode & m_sticky[i]);
      end
      return pend;
   endfunction

   // Urgency grows with the level, or falls in reverse mode
   function automatic pic_pkg::prio_t urgency(input pic_pkg::prio_t p);
      return m_reverse ? pic_pkg::PRIO_MAX - p : p;
   endfunction

   function automatic claim_exp_t ref_claim(input logic [NUM_SRC-1:0] pend);
      claim_exp_t     e;
      pic_pkg::prio_t best;
      best = '0;
      e.id = '0;
      for (int i = 1; i < NUM_SRC; i++) begin
         if (pend[i] && m_enable[i] && (urgency(m_prio[i]) > best)) begin   // Ties keep lower id
            best = urgency(m_prio[i]);
            e.id = pic_pkg::id_t'(i);
         end
      end
      e.pl       = urgency(best);
      e.ext_pend = (best > urgency(m_thr)) && (best > urgency(m_cur));
      e.wake     = (best == pic_pkg::PRIO_MAX);
      return e;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic stop_run();
      $display("Test failed");
      $fatal(1, "Run stopped at the first mismatch");
   endtask

   task automatic check_rd_data(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_claim(input string name, input pic_pkg::id_t exp_id,
                              input pic_pkg::prio_t exp_pl, input pic_pkg::id_t act_id,
                              input pic_pkg::prio_t act_pl);
      if ((act_id !== exp_id) || (act_pl !== exp_pl)) begin
         $display("ERROR %s: expected id %0d pl %0d, actual id %0d pl %0d",
                  name, exp_id, exp_pl, act_id, act_pl);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
         stop_run();
      end
   endtask

   initial begin : compare_outputs
      claim_exp_t e;
      forever begin
         @(check_req);
         e = ref_claim(pend_model());
         check_claim(cur_test, e.id, e.pl, claimid, pl);
         check_flag({cur_test, " mexintpend"}, e.ext_pend, mexintpend);
         check_flag({cur_test, " mhwakeup"}, e.wake, mhwakeup);
         check_busy = 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bus and stimulus tasks
   //////////////////////////////////////////////////////////////////////
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk);
      picm_wren    <= 1'b1;
      picm_wraddr  <= addr;
      picm_wr_data <= data;
      @(posedge clk);
      picm_wren    <= 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      @(posedge clk);
      picm_rden   <= 1'b1;
      picm_rdaddr <= addr;
      @(posedge clk);
      picm_rden   <= 1'b0;
      @(negedge clk);
      data = picm_rd_data;   // Valid the cycle after the strobe
   endtask

   task automatic bus_read_write(input logic [31:0] addr, input logic [31:0] wdata,
                                 output logic [31:0] rdata);
      @(posedge clk);
      picm_rden    <= 1'b1;
      picm_rdaddr  <= addr;
      picm_wren    <= 1'b1;
      picm_wraddr  <= addr;
      picm_wr_data <= wdata;
      @(posedge clk);
      picm_rden    <= 1'b0;
      picm_wren    <= 1'b0;
      @(negedge clk);
      rdata = picm_rd_data;
   endtask

   task automatic set_model(input int kind, input int idx, input logic [31:0] data);
      if (kind == 3) begin
         m_reverse = data[0];
      end else if (idx != 0) begin
         case (kind)
            0:       m_prio[idx]   = data[3:0];
            1:       m_enable[idx] = data[0];
            default: m_gw_cfg[idx] = pic_pkg::gw_cfg_t'(data[1:0]);
         endcase
      end
   endtask

   task automatic reg_write(input int kind, input int idx, input logic [31:0] data);
      bus_write(reg_addr(kind, idx), data);
      set_model(kind, idx, data);
   endtask

   task automatic clear_gateway(input int idx);
      bus_write(BASE + pic_pkg::GW_CLEAR_OFFSET + 32'(4 * idx), '0);
      m_sticky[idx] = 1'b0;
   endtask

   task automatic drive_inputs();
      @(posedge clk);
      extintsrc_req <= m_src;
      meipt         <= m_thr;
      meicurpl      <= m_cur;
   endtask

   task automatic wait_stable();
      repeat (8) @(posedge clk);
      @(negedge clk);
   endtask

   task automatic request_check(input string name);
      cur_test   = name;
      check_busy = 1'b1;
      -> check_req;
      wait (!check_busy);
   endtask

   task automatic check_pending(input string name);
      logic [31:0] rdata;
      bus_read(BASE + pic_pkg::PEND_OFFSET, rdata);
      check_rd_data(name, 32'(pend_model()), rdata);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////
   initial begin : main_seq
      logic [31:0]    rdata;
      logic [31:0]    wdata;
      int             kind;
      int             idx;
      pic_pkg::prio_t level;
      void'($urandom(SEED));
      reset         = 1'b1;
      picm_rden     = 1'b0;
      picm_rdaddr   = '0;
      picm_wren     = 1'b0;
      picm_wraddr   = '0;
      picm_wr_data  = '0;
      extintsrc_req = '0;
      meipt         = '0;
      meicurpl      = '0;
      check_busy    = 1'b0;
      for (int i = 0; i < NUM_SRC; i++) begin
         m_prio[i]   = '0;
         m_enable[i] = 1'b0;
         m_gw_cfg[i] = '0;
      end
      m_reverse = 1'b0;
      m_src     = '0;
      m_sticky  = '0;
      m_thr     = '0;
      m_cur     = '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;

      // Source 0 ignores writes of every kind
      for (int k = 0; k < 3; k++) begin
         reg_write(k, 0, '1);
         bus_read(reg_addr(k, 0), rdata);
         check_rd_data("reg_source0", exp_read(k, 0), rdata);
      end

      // Register round trip, source 0 included
      for (int t = 0; t < N_REG; t++) begin
         kind  = $urandom_range(0, 3);
         idx   = $urandom_range(0, NUM_SRC - 1);
         wdata = $urandom;
         reg_write(kind, idx, wdata);
         bus_read(reg_addr(kind, idx), rdata);
         check_rd_data("reg_round_trip", exp_read(kind, idx), rdata);
      end

      for (int t = 0; t < N_BYP; t++) begin
         kind  = $urandom_range(0, 2);
         idx   = $urandom_range(1, NUM_SRC - 1);
         wdata = $urandom;
         bus_read_write(reg_addr(kind, idx), wdata, rdata);
         set_model(kind, idx, wdata);
         check_rd_data("bypass", wdata, rdata);
      end

      // Level gateways with random polarity for arbitration
      reg_write(3, 0, 32'h0);
      for (int i = 1; i < NUM_SRC; i++) begin
         reg_write(2, i, 32'($urandom_range(0, 1)));
         reg_write(0, i, 32'($urandom_range(0, 15)));
         reg_write(1, i, 32'($urandom_range(0, 1)));
      end
      for (int t = 0; t < N_ARB; t++) begin
         for (int k = 0; k < 4; k++) begin
            reg_write(0, $urandom_range(1, NUM_SRC - 1), 32'($urandom_range(0, 15)));
            reg_write(1, $urandom_range(1, NUM_SRC - 1), 32'($urandom_range(0, 1)));
         end
         if ($urandom_range(0, 7) == 0) begin
            reg_write(3, 0, {31'b0, ~m_reverse});
         end
         m_src = $urandom;
         drive_inputs();
         wait_stable();
         request_check("arbitration");
      end

      // Threshold sweep with source 7 at the top level or a middle one
      for (int mode = 0; mode < 2; mode++) begin
         for (int sel = 0; sel < 2; sel++) begin
            reg_write(3, 0, 32'(mode));
            level = (sel == 0) ? urgency(pic_pkg::PRIO_MAX) : 4'($urandom_range(4, 11));
            reg_write(0, 7, {28'b0, level});
            reg_write(1, 7, 32'h1);
            m_src[7] = ~m_gw_cfg[7].polarity;
            for (int thr = 0; thr < 16; thr++) begin
               m_thr = pic_pkg::prio_t'(thr);
               m_cur = thr[0] ? 4'($urandom_range(0, 15)) : urgency('0);
               drive_inputs();
               wait_stable();
               request_check("threshold");
            end
         end
      end

      // Active low level source
      reg_write(2, 5, 32'h1);
      m_src[5] = 1'b0;
      drive_inputs();
      wait_stable();
      check_pending("gateway active low on");
      m_src[5] = 1'b1;
      drive_inputs();
      wait_stable();
      check_pending("gateway active low off");

      // Edge source, flush the sticky flop first
      m_src[9] = 1'b0;
      drive_inputs();
      reg_write(2, 9, 32'h2);
      clear_gateway(9);
      wait_stable();
      check_pending("gateway edge idle");
      m_src[9] = 1'b1;
      drive_inputs();
      repeat (4) @(posedge clk);
      m_src[9]    = 1'b0;
      m_sticky[9] = 1'b1;
      drive_inputs();
      wait_stable();
      check_pending("gateway edge held");
      request_check("gateway claim");
      clear_gateway(9);
      wait_stable();
      check_pending("gateway edge cleared");

      if (pic_ctrl_inst.assert_inst.failures == 0) begin
         $display("Test passed");
      end else begin
         $display("Assertion failures seen: %0d", pic_ctrl_inst.assert_inst.failures);
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* sim/pic_ctrl_assert.sv */
// PIC output checks
// Concurrent assertions on the claim outputs and the register read port

module pic_ctrl_assert #(
   parameter int NUM_SOURCES = 32
) (
   input logic           clk,
   input logic           reset,
   input logic           picm_rden,
   input logic [31:0]    picm_rd_data,
   input pic_pkg::id_t   claimid,
   input pic_pkg::prio_t pl,
   input logic           mexintpend,
   input logic           mhwakeup,
   input logic           prio_reverse
);

   int unsigned failures = 0;   // Failed assertions so far

   claimid_range: assert property (@(posedge clk) disable iff (reset)
      claimid < NUM_SOURCES)
      else begin
         $error("claimid %0d outside the source range", claimid);
         failures++;
      end

   // Most urgent level is 0 in reverse mode
   wake_level: assert property (@(posedge clk) disable iff (reset)
      mhwakeup |-> (pl == ($past(prio_reverse) ? 4'd0 : pic_pkg::PRIO_MAX)))
      else begin
         $error("mhwakeup with pl %0d", pl);
         failures++;
      end

   outputs_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({claimid, pl, mexintpend, mhwakeup, picm_rd_data}))
      else begin
         $error("X on a core output or the read data");
         failures++;
      end

   rd_idle_zero: assert property (@(posedge clk) disable iff (reset)
      !$past(picm_rden) |-> (picm_rd_data == '0))
      else begin
         $error("picm_rd_data 0x%08h with no read in flight", picm_rd_data);
         failures++;
      end

endmodule

bind pic_ctrl pic_ctrl_assert #(.NUM_SOURCES(NUM_SOURCES)) assert_inst (
   .clk, .reset, .picm_rden, .picm_rd_data,
   .claimid, .pl, .mexintpend, .mhwakeup, .prio_reverse
);

/* source/pic_ctrl.sv */
// Programmable interrupt controller for one hart
// Register stage, gateway stage, arbitration stage and claim stage

module pic_ctrl #(
   parameter int          NUM_SOURCES = 32,              // Includes reserved source 0
   parameter logic [31:0] BASE_ADDR   = 32'hF00C_0000,
   parameter int          TWO_CYCLE   = 0                // 1 adds the mid-tree register
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     picm_rden,
   input  logic [31:0]              picm_rdaddr,
   input  logic                     picm_wren,
   input  logic [31:0]              picm_wraddr,
   input  logic [31:0]              picm_wr_data,
   input  logic [NUM_SOURCES-1:0]   extintsrc_req,
   input  pic_pkg::prio_t           meipt,
   input  pic_pkg::prio_t           meicurpl,
   output logic [31:0]              picm_rd_data,
   output pic_pkg::id_t             claimid,
   output pic_pkg::prio_t           pl,
   output logic                     mexintpend,
   output logic                     mhwakeup
);

   pic_pkg::gw_cfg_t [NUM_SOURCES-1:0]  gw_cfg;
   logic [NUM_SOURCES-1:0]              gw_clear;
   pic_pkg::prio_t [NUM_SOURCES-1:0]    eff_prio;
   logic [NUM_SOURCES-1:0]              enable;
   logic                                prio_reverse;
   logic [NUM_SOURCES-1:0]              gw_req;
   pic_pkg::cand_t                      winner;

   pic_reg_file #(.NUM_SOURCES(NUM_SOURCES), .BASE_ADDR(BASE_ADDR)) reg_file_inst (
      .clk, .reset,
      .picm_rden, .picm_rdaddr, .picm_wren, .picm_wraddr, .picm_wr_data,
      .gw_req, .picm_rd_data,
      .gw_cfg, .gw_clear, .eff_prio, .enable, .prio_reverse
   );

   pic_gateway_array #(.NUM_SOURCES(NUM_SOURCES)) gateway_inst (
      .clk, .reset, .extintsrc_req, .gw_cfg, .gw_clear, .gw_req
   );

   pic_priority_tree #(.NUM_SOURCES(NUM_SOURCES), .TWO_CYCLE(TWO_CYCLE)) tree_inst (
      .clk, .reset, .gw_req, .enable, .eff_prio, .winner
   );

   pic_claim_stage claim_inst (
      .clk, .reset, .winner, .prio_reverse, .meipt, .meicurpl,
      .claimid, .pl, .mexintpend, .mhwakeup
   );

endmodule

/* source/pic_claim_stage.sv */
// PIC claim stage
// Restores the priority encoding of the winner, checks it against the
// threshold and current level and registers the core-side outputs

module pic_claim_stage (
   input  logic               clk,
   input  logic               reset,
   input  pic_pkg::cand_t     winner,
   input  logic               prio_reverse,
   input  pic_pkg::prio_t     meipt,          // Threshold
   input  pic_pkg::prio_t     meicurpl,       // Level being serviced
   output pic_pkg::id_t       claimid,
   output pic_pkg::prio_t     pl,
   output logic               mexintpend,
   output logic               mhwakeup
);

   pic_pkg::prio_t  pl_d;
   pic_pkg::prio_t  meipt_eff;
   pic_pkg::prio_t  curpl_eff;
   pic_pkg::prio_t  max_level;
   logic            mexintpend_d;
   logic            mhwakeup_d;

   // Tree works on effective levels, undo the inversion for pl
   assign pl_d      = prio_reverse ? ~winner.prio : winner.prio;

   // Compare in the effective domain
   assign meipt_eff = prio_reverse ? ~meipt : meipt;
   assign curpl_eff = prio_reverse ? ~meicurpl : meicurpl;

   assign mexintpend_d = (winner.prio > meipt_eff) & (winner.prio > curpl_eff);

   assign max_level  = prio_reverse ? '0 : pic_pkg::PRIO_MAX;
   assign mhwakeup_d = (pl_d == max_level);   // Most urgent level wakes the core

   always_ff @(posedge clk) begin
      if (reset) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= winner.id;
         pl         <= pl_d;
         mexintpend <= mexintpend_d;
         mhwakeup   <= mhwakeup_d;
      end
   end

endmodule

/* source/pic_priority_tree.sv */
// PIC arbitration stage
// Masks each source by pending and enable, then reduces the candidates
// pairwise to one winner. Optional register halfway down the tree.

module pic_priority_tree #(
   parameter int NUM_SOURCES = 32,
   parameter int TWO_CYCLE   = 0
) (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [NUM_SOURCES-1:0]               gw_req,
   input  logic [NUM_SOURCES-1:0]               enable,
   input  pic_pkg::prio_t [NUM_SOURCES-1:0]     eff_prio,
   output pic_pkg::cand_t                       winner
);

   localparam int NUM_LEVELS = $clog2(NUM_SOURCES);
   localparam int LEAVES     = 2 ** NUM_LEVELS;      // Padded to a full tree
   localparam int MID        = NUM_LEVELS / 2;       // Level of the optional register
   localparam int MID_W      = LEAVES >> MID;

   pic_pkg::prio_t [LEAVES-1:0]  leaf_prio;
   pic_pkg::cand_t               mid_d   [MID_W];
   pic_pkg::cand_t               mid_sel [MID_W];

   // Keep a unless b is strictly higher, ties go to the lower id
   function automatic pic_pkg::cand_t cmp_sel(input pic_pkg::cand_t a,
                                              input pic_pkg::cand_t b);
      return (b.prio > a.prio) ? b : a;
   endfunction

   always_comb begin
      leaf_prio = '0;   // Pads stay at 0
      for (int i = 0; i < NUM_SOURCES; i++) begin
         leaf_prio[i] = (gw_req[i] & enable[i]) ? eff_prio[i] : '0;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Upper half of the tree
   ///////////////////////////////////////////////////////////////////////
   always_comb begin : upper_half
      pic_pkg::cand_t lvl [LEAVES];
      for (int i = 0; i < LEAVES; i++) begin
         lvl[i].id   = pic_pkg::id_t'(i);
         lvl[i].prio = leaf_prio[i];
      end
      // Reduce in place, entry m is written after 2m and 2m+1 are read
      for (int l = 0; l < MID; l++) begin
         for (int m = 0; m < (LEAVES >> (l + 1)); m++) begin
            lvl[m] = cmp_sel(lvl[2*m], lvl[2*m+1]);
         end
      end
      for (int j = 0; j < MID_W; j++) begin
         mid_d[j] = lvl[j];
      end
   end

   if (TWO_CYCLE != 0) begin : gen_mid_reg
      pic_pkg::cand_t mid_q [MID_W];

      always_ff @(posedge clk) begin
         if (reset) begin
            mid_q <= '{default: '0};
         end else begin
            mid_q <= mid_d;
         end
      end
      assign mid_sel = mid_q;
   end else begin : gen_mid_comb
      assign mid_sel = mid_d;   // Straight through
   end

   ///////////////////////////////////////////////////////////////////////
   // Lower half of the tree
   ///////////////////////////////////////////////////////////////////////
   always_comb begin : lower_half
      pic_pkg::cand_t lvl [MID_W];
      lvl = mid_sel;
      for (int l = MID; l < NUM_LEVELS; l++) begin
         for (int m = 0; m < (LEAVES >> (l + 1)); m++) begin
            lvl[m] = cmp_sel(lvl[2*m], lvl[2*m+1]);
         end
      end
      winner = lvl[0];
   end

endmodule

/* source/pic_gateway_array.sv */
// PIC gateway stage
// Synchronizes each external source, corrects its polarity and either
// passes the level or holds it in a sticky pending flop until cleared

module pic_gateway_array #(
   parameter int NUM_SOURCES = 32
) (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [NUM_SOURCES-1:0]               extintsrc_req,   // Asynchronous levels
   input  pic_pkg::gw_cfg_t [NUM_SOURCES-1:0]   gw_cfg,
   input  logic [NUM_SOURCES-1:0]               gw_clear,
   output logic [NUM_SOURCES-1:0]               gw_req
);

   // Source 0 is reserved
   assign gw_req[0] = 1'b0;

   ///////////////////////////////////////////////////////////////////////
   // One gateway per source
   ///////////////////////////////////////////////////////////////////////
   for (genvar i = 1; i < NUM_SOURCES; i++) begin : gen_gw
      logic sync_q1;
      logic sync_q2;
      logic pend_q;
      logic level;
      logic pend_d;

      // Two-flop synchronizer
      always_ff @(posedge clk) begin
         if (reset) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
         end else begin
            sync_q1 <= extintsrc_req[i];
            sync_q2 <= sync_q1;
         end
      end

      assign level  = sync_q2 ^ gw_cfg[i].polarity;        // Active high from here on
      assign pend_d = level | (pend_q & ~gw_clear[i]);     // Hold until meigwclr

      always_ff @(posedge clk) begin
         if (reset) begin
            pend_q <= 1'b0;
         end else begin
            pend_q <= pend_d;
         end
      end

      // Edge sources see the sticky copy as well
      assign gw_req[i] = gw_cfg[i].edge_mode ? (level | pend_q) : level;
   end

endmodule

/* source/pic_reg_file.sv */
// PIC register stage
// Registers the bus strobes, decodes the register map and holds the
// priority, enable, gateway and priority order registers. Builds the
// read data with write-to-read bypass.

module pic_reg_file #(
   parameter int          NUM_SOURCES = 32,
   parameter logic [31:0] BASE_ADDR   = 32'hF00C_0000
) (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 picm_rden,
   input  logic [31:0]                          picm_rdaddr,
   input  logic                                 picm_wren,
   input  logic [31:0]                          picm_wraddr,
   input  logic [31:0]                          picm_wr_data,
   input  logic [NUM_SOURCES-1:0]               gw_req,        // Gateway outputs for meip
   output logic [31:0]                          picm_rd_data,
   output pic_pkg::gw_cfg_t [NUM_SOURCES-1:0]   gw_cfg,
   output logic [NUM_SOURCES-1:0]               gw_clear,
   output pic_pkg::prio_t [NUM_SOURCES-1:0]     eff_prio,
   output logic [NUM_SOURCES-1:0]               enable,
   output logic                                 prio_reverse
);

   localparam int NUM_LEVELS = $clog2(NUM_SOURCES);
   localparam int HI         = NUM_LEVELS + 2;              // First bit above the word index
   localparam int PEND_WORDS = (NUM_SOURCES + 31) / 32;

   localparam logic [31:0] PRIO_ADDR     = BASE_ADDR + pic_pkg::PRIO_OFFSET;
   localparam logic [31:0] PEND_ADDR     = BASE_ADDR + pic_pkg::PEND_OFFSET;
   localparam logic [31:0] ENABLE_ADDR   = BASE_ADDR + pic_pkg::ENABLE_OFFSET;
   localparam logic [31:0] CONFIG_ADDR   = BASE_ADDR + pic_pkg::CONFIG_OFFSET;
   localparam logic [31:0] GW_CFG_ADDR   = BASE_ADDR + pic_pkg::GW_CONFIG_OFFSET;
   localparam logic [31:0] GW_CLEAR_ADDR = BASE_ADDR + pic_pkg::GW_CLEAR_OFFSET;

   pic_pkg::bus_req_t                 bus_q;
   logic [NUM_LEVELS-1:0]             ridx;
   logic [NUM_LEVELS-1:0]             widx;
   logic                              rd_prio, rd_pend, rd_enable, rd_gw_cfg, rd_config;
   logic                              wr_prio, wr_enable, wr_gw_cfg, wr_gw_clear, wr_config;
   pic_pkg::prio_t [NUM_SOURCES-1:0]  prio_reg;
   logic [PEND_WORDS*32-1:0]          pend_ext;
   logic [31:0]                       rd_mux;
   logic                              bypass;

   ///////////////////////////////////////////////////////////////////////
   // Bus input register
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      bus_q.raddr <= picm_rdaddr;
      bus_q.waddr <= picm_wraddr;
      bus_q.wdata <= picm_wr_data;
      if (reset) begin
         bus_q.rden <= 1'b0;
         bus_q.wren <= 1'b0;
      end else begin
         bus_q.rden <= picm_rden;
         bus_q.wren <= picm_wren;
      end
   end

   assign ridx = bus_q.raddr[HI-1:2];   // Source or pending word
   assign widx = bus_q.waddr[HI-1:2];

   // Block decode on the bits above the index
   assign rd_prio     = bus_q.rden & (bus_q.raddr[31:HI] == PRIO_ADDR[31:HI]);
   assign rd_pend     = bus_q.rden & (bus_q.raddr[31:HI] == PEND_ADDR[31:HI]);
   assign rd_enable   = bus_q.rden & (bus_q.raddr[31:HI] == ENABLE_ADDR[31:HI]);
   assign rd_gw_cfg   = bus_q.rden & (bus_q.raddr[31:HI] == GW_CFG_ADDR[31:HI]);
   assign rd_config   = bus_q.rden & (bus_q.raddr == CONFIG_ADDR);    // Single register

   assign wr_prio     = bus_q.wren & (bus_q.waddr[31:HI] == PRIO_ADDR[31:HI]);
   assign wr_enable   = bus_q.wren & (bus_q.waddr[31:HI] == ENABLE_ADDR[31:HI]);
   assign wr_gw_cfg   = bus_q.wren & (bus_q.waddr[31:HI] == GW_CFG_ADDR[31:HI]);
   assign wr_gw_clear = bus_q.wren & (bus_q.waddr[31:HI] == GW_CLEAR_ADDR[31:HI]);
   assign wr_config   = bus_q.wren & (bus_q.waddr == CONFIG_ADDR);

   ///////////////////////////////////////////////////////////////////////
   // Configuration registers
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         prio_reg     <= '0;
         enable       <= '0;
         gw_cfg       <= '0;
         prio_reverse <= 1'b0;
      end else begin
         // Loop starts at 1, source 0 stays zero
         for (int i = 1; i < NUM_SOURCES; i++) begin
            if (wr_prio && (widx == i)) begin
               prio_reg[i] <= bus_q.wdata[pic_pkg::PRIO_BITS-1:0];
            end
            if (wr_enable && (widx == i)) begin
               enable[i] <= bus_q.wdata[0];
            end
            if (wr_gw_cfg && (widx == i)) begin
               gw_cfg[i] <= pic_pkg::gw_cfg_t'(bus_q.wdata[1:0]);
            end
         end
         if (wr_config) begin
            prio_reverse <= bus_q.wdata[0];
         end
      end
   end

   // Clear pulse lasts the registered write cycle only
   always_comb begin
      gw_clear = '0;
      for (int i = 1; i < NUM_SOURCES; i++) begin
         gw_clear[i] = wr_gw_clear & (widx == i);
      end
   end

   // Reverse order turns the tree into a search for the lowest level
   always_comb begin
      for (int i = 0; i < NUM_SOURCES; i++) begin
         eff_prio[i] = prio_reverse ? ~prio_reg[i] : prio_reg[i];
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Read data
   ///////////////////////////////////////////////////////////////////////
   always_comb begin
      pend_ext                   = '0;
      pend_ext[NUM_SOURCES-1:0]  = gw_req;
   end

   always_comb begin
      rd_mux = '0;
      for (int i = 1; i < NUM_SOURCES; i++) begin
         if (ridx == i) begin
            if (rd_prio) begin
               rd_mux[pic_pkg::PRIO_BITS-1:0] = prio_reg[i];
            end
            if (rd_enable) begin
               rd_mux[0] = enable[i];
            end
            if (rd_gw_cfg) begin
               rd_mux[1:0] = gw_cfg[i];
            end
         end
      end
      for (int w = 0; w < PEND_WORDS; w++) begin
         if (rd_pend && (ridx == w)) begin
            rd_mux = pend_ext[32*w +: 32];   // 32 sources per word
         end
      end
      if (rd_config) begin
         rd_mux[0] = prio_reverse;
      end
   end

   assign bypass       = bus_q.rden & bus_q.wren & (bus_q.raddr == bus_q.waddr);
   assign picm_rd_data = bypass ? bus_q.wdata : rd_mux;   // Same-cycle write wins

endmodule

/* source/pic_pkg.sv */
// PIC shared definitions
// Widths, register map offsets and the packed types passed between
// the register, gateway, arbitration and claim stages

package pic_pkg;

   ///////////////////////////////////////////////////////////////////////
   // Widths
   ///////////////////////////////////////////////////////////////////////
   localparam int PRIO_BITS = 4;                  // Priority level width
   localparam int ID_BITS   = 8;                  // Claim id width, up to 256 sources

   typedef logic [PRIO_BITS-1:0] prio_t;
   typedef logic [ID_BITS-1:0]   id_t;

   localparam prio_t PRIO_MAX = 4'd15;           // Highest level in normal mode

   ///////////////////////////////////////////////////////////////////////
   // Register map, offsets from the base address
   ///////////////////////////////////////////////////////////////////////
   localparam logic [31:0] PRIO_OFFSET      = 32'h0000_0000;   // meipl per source
   localparam logic [31:0] PEND_OFFSET      = 32'h0000_1000;   // meip, 32 sources per word
   localparam logic [31:0] ENABLE_OFFSET    = 32'h0000_2000;   // meie per source
   localparam logic [31:0] CONFIG_OFFSET    = 32'h0000_3000;   // mpiccfg, priority order
   localparam logic [31:0] GW_CONFIG_OFFSET = 32'h0000_4000;   // meigwctrl per source
   localparam logic [31:0] GW_CLEAR_OFFSET  = 32'h0000_5000;   // meigwclr per source

   ///////////////////////////////////////////////////////////////////////
   // Shared structs
   ///////////////////////////////////////////////////////////////////////

   // Gateway control, bit 1 type and bit 0 polarity as on the bus
   typedef struct packed {
      logic edge_mode;                           // 1 = sticky edge capture
      logic polarity;                            // 1 = active low source
   } gw_cfg_t;

   // One entry of the compare tree
   typedef struct packed {
      id_t   id;
      prio_t prio;
   } cand_t;

   // Bus request as seen one cycle after the strobes
   typedef struct packed {
      logic        rden;
      logic        wren;
      logic [31:0] raddr;
      logic [31:0] waddr;
      logic [31:0] wdata;
   } bus_req_t;

endpackage
